// File: build.f
+incdir+verification
src/privPkg.sv
src/faultPipe.sv
src/privDecode.sv
src/trapUnit.sv
src/csrFile.sv
src/privileged.sv
verification/privilegedTb.sv

// File: verification/privilegedTests.svh
/* directed tests: CSR round trip, ecall, returns and delegation,
   fault pipeline timing, illegal operations and exception priority */

// switch from M to a lower mode with mret, mcause cleared on the way
task automatic enterMode(input logic [1:0] mode);
  writeCsr(csrMcause, '0);
  writeCsr(csrMstatus, xlen'(mode) << mstatusMpp);
  writeCsr(csrMepc, 32'h0000_0500);
  execSys(privInstr(funct12Mret), 32'h0000_0600, 1'b0, 1'b1, 1'b0, 32'h0000_0500);
  checkMode("privModeW", privModeW, mode);
endtask

// access fault at F; edge count until trapM, zero if none
task automatic pushFault(input logic withFlush, input logic withStall, output int arrival);
  int k;
  arrival = 0;
  pcM = 32'h0000_0700;
  instrValidM = 1'b1;
  instrAccessFaultF = 1'b1;
  for (k = 1; k <= 6; k++) begin
    nextEdge();
    instrAccessFaultF = 1'b0;
    // edge 2 stalls decode and puts a bubble into execute
    stallD = withStall && k == 1;
    flushE = (withStall || withFlush) && k == 1;
    @(negedge clk);
    if (trapM && arrival != 0) begin
      errorCount++;
      $display("fault trapped a second time at %0t", $time);
    end else if (trapM) begin
      arrival = k;
      checkWord("privNextPcM", privNextPcM, mtvecVal);
    end
  end
  nextEdge();
  clearInputs();
endtask

task automatic csrRoundTrip();
  logic [xlen-1:0] epcVal, delegVal;
  mtvecVal = $urandom;
  stvecVal = $urandom;
  epcVal   = $urandom;
  delegVal = $urandom;
  writeCsr(csrMtvec, mtvecVal);
  writeCsr(csrStvec, stvecVal);
  writeCsr(csrMepc, epcVal);
  writeCsr(csrMedeleg, delegVal);
  // direct mode keeps only the base
  mtvecVal = mtvecVal & ~32'h3;
  stvecVal = stvecVal & ~32'h3;
  readCsrCheck(csrMtvec, mtvecVal);
  readCsrCheck(csrStvec, stvecVal);
  readCsrCheck(csrMepc, epcVal);
  readCsrCheck(csrMedeleg, delegVal);
endtask

task automatic ecallInM();
  execSys(privInstr(funct12Ecall), 32'h0000_1234, 1'b1, 1'b0, 1'b0, mtvecVal);
  checkMode("privModeW", privModeW, modeM);
  readCsrCheck(csrMcause, causeEcallU + 3);
  readCsrCheck(csrMepc, 32'h0000_1234);
  // MPP = M, MIE and MPIE were zero
  readCsrCheck(csrMstatus, 32'h0000_1800);
endtask

task automatic returnAndDelegate();
  writeCsr(csrMstatus, 32'h0000_0800);
  writeCsr(csrMepc, 32'h0000_4000);
  // delegate ecall from S
  writeCsr(csrMedeleg, 32'h0000_0200);
  execSys(privInstr(funct12Mret), 32'h0000_0100, 1'b0, 1'b1, 1'b0, 32'h0000_4000);
  checkMode("privModeW", privModeW, modeS);
  execSys(privInstr(funct12Ecall), 32'h0000_4000, 1'b1, 1'b0, 1'b0, stvecVal);
  checkMode("privModeW", privModeW, modeS);
  readCsrCheck(csrScause, causeEcallU + 1);
  readCsrCheck(csrSepc, 32'h0000_4000);
  // only SPP visible, SIE and SPIE still clear
  readCsrCheck(csrSstatus, 32'h0000_0100);
  execSys(privInstr(funct12Sret), 32'h0000_4010, 1'b0, 1'b1, 1'b0, 32'h0000_4000);
  checkMode("privModeW", privModeW, modeS);
  // SPP now U, so a second sret drops to U
  execSys(privInstr(funct12Sret), 32'h0000_4020, 1'b0, 1'b1, 1'b0, 32'h0000_4000);
  checkMode("privModeW", privModeW, modeU);
endtask

task automatic faultPipeline();
  int arrival;
  pushFault(1'b0, 1'b0, arrival);
  checkWord("fault arrival edge", xlen'(arrival), 3);
  checkMode("privModeW", privModeW, modeM);
  readCsrCheck(csrMcause, causeInstrAccess);
  readCsrCheck(csrMepc, 32'h0000_0700);
  pushFault(1'b1, 1'b0, arrival);
  checkWord("fault arrival edge", xlen'(arrival), 0);
  pushFault(1'b0, 1'b1, arrival);
  checkWord("fault arrival edge", xlen'(arrival), 4);
endtask

task automatic illegalOps();
  // M-only CSR touched from S
  enterMode(modeS);
  csrReadM = 1'b1;
  execSys(csrInstr(csrMcause), 32'h0000_0a00, 1'b1, 1'b0, 1'b0, mtvecVal);
  checkMode("privModeW", privModeW, modeM);
  readCsrCheck(csrMcause, causeIllegal);
  enterMode(modeU);
  execSys(privInstr(funct12Sret), 32'h0000_0b00, 1'b1, 1'b0, 1'b0, mtvecVal);
  checkMode("privModeW", privModeW, modeM);
  readCsrCheck(csrMcause, causeIllegal);
  enterMode(modeU);
  execSys(sfenceInstr(), 32'h0000_0c00, 1'b1, 1'b0, 1'b0, mtvecVal);
  checkMode("privModeW", privModeW, modeM);
  readCsrCheck(csrMcause, causeIllegal);
  // legal in S, flush only
  enterMode(modeS);
  execSys(sfenceInstr(), 32'h0000_0d00, 1'b0, 1'b0, 1'b1, '0);
  checkMode("privModeW", privModeW, modeS);
endtask

task automatic trapPriority();
  // page fault from F and illegal from D meet in M on edge 3
  instrPageFaultF = 1'b1;
  nextEdge();
  instrPageFaultF = 1'b0;
  illegalInstrD = 1'b1;
  nextEdge();
  illegalInstrD = 1'b0;
  nextEdge();
  instrValidM = 1'b1;
  @(negedge clk);
  checkBit("trapM", trapM, 1'b1);
  checkWord("privNextPcM", privNextPcM, mtvecVal);
  nextEdge();
  clearInputs();
  checkMode("privModeW", privModeW, modeM);
  readCsrCheck(csrMcause, causeInstrPage);
  // breakpoint outranks load access
  loadAccessFaultM = 1'b1;
  execSys(privInstr(funct12Ebreak), 32'h0000_0e00, 1'b1, 1'b0, 1'b0, mtvecVal);
  readCsrCheck(csrMcause, causeBreakpoint);
endtask

// File: verification/privilegedTb.sv
/* testbench for the privileged unit with clock, reset, DUT, compare tasks,
   drive helpers, cycle limit and run summary */
module privilegedTb;
  timeunit 1ns;
  timeprecision 100ps;
  import privPkg::*;

  logic clk;
  logic rstN;
  logic stallD, stallE, stallM, stallW;
  logic flushD, flushE, flushM;
  logic instrAccessFaultF, instrPageFaultF, illegalInstrD;
  sysInstr_t instrM;
  logic instrValidM;
  logic [xlen-1:0] pcM, srcAM;
  logic csrReadM, csrWriteM;
  logic loadAccessFaultM, storeAccessFaultM;
  logic trapM, retM, tlbFlushM;
  logic [xlen-1:0] privNextPcM, csrReadValW;
  logic [1:0] privModeW;

  int checkCount;
  int errorCount;
  int cycleCount;
  // expected csrReadValW between reads
  logic [xlen-1:0] lastRead;
  // tvec values as the tests wrote them, low bits cleared
  logic [xlen-1:0] mtvecVal, stvecVal;

  privileged privileged_i (.*);

  ////////////////////////////////////////////////////////////
  // clock and cycle limit
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // directed tests finish well inside this bound
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= 400) begin
      $display("timeout: tests still running after %0d cycles", cycleCount);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic checkWord(input string name, input logic [xlen-1:0] act,
                           input logic [xlen-1:0] exp);
    checkCount++;
    if (act !== exp) begin
      errorCount++;
      $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic checkMode(input string name, input logic [1:0] act, input logic [1:0] exp);
    checkCount++;
    if (act !== exp) begin
      errorCount++;
      $display("mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic checkBit(input string name, input logic act, input logic exp);
    checkCount++;
    if (act !== exp) begin
      errorCount++;
      $display("mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // instruction words and drive helpers
  ////////////////////////////////////////////////////////////

  // csrrw rd=x2, rs1=x1
  function automatic sysInstr_t csrInstr(input logic [11:0] addr);
    sysInstr_t w;
    w.csrView.csrAddr = addr;
    w.csrView.rs1     = 5'd1;
    w.csrView.funct3  = 3'b001;
    w.csrView.rd      = 5'd2;
    w.csrView.opcode  = opSystem;
    return w;
  endfunction

  // mret, sret, ecall and ebreak
  function automatic sysInstr_t privInstr(input logic [11:0] funct12);
    sysInstr_t w;
    w = '0;
    w.csrView.csrAddr = funct12;
    w.csrView.opcode  = opSystem;
    return w;
  endfunction

  // sfence.vma with nonzero address and ASID registers
  function automatic sysInstr_t sfenceInstr();
    sysInstr_t w;
    w = '0;
    w.fenceView.funct7 = funct7SfenceVma;
    w.fenceView.rs2    = 5'd4;
    w.fenceView.rs1    = 5'd3;
    w.fenceView.opcode = opSystem;
    return w;
  endfunction

  task automatic clearInputs();
    {stallD, stallE, stallM, stallW} = '0;
    {flushD, flushE, flushM} = '0;
    {instrAccessFaultF, instrPageFaultF, illegalInstrD} = '0;
    {loadAccessFaultM, storeAccessFaultM} = '0;
    {csrReadM, csrWriteM, instrValidM} = '0;
    instrM = '0;
    pcM    = '0;
    srcAM  = '0;
  endtask

  // inputs change 2 ns after the rising edge
  task automatic nextEdge();
    @(posedge clk);
    #2;
  endtask

  task automatic writeCsr(input logic [11:0] addr, input logic [xlen-1:0] data);
    instrM      = csrInstr(addr);
    srcAM       = data;
    csrWriteM   = 1'b1;
    instrValidM = 1'b1;
    @(negedge clk);
    checkBit("trapM", trapM, 1'b0);
    nextEdge();
    clearInputs();
  endtask

  // read data must not show before the commit edge
  task automatic readCsrCheck(input logic [11:0] addr, input logic [xlen-1:0] exp);
    instrM      = csrInstr(addr);
    csrReadM    = 1'b1;
    instrValidM = 1'b1;
    @(negedge clk);
    checkBit("trapM", trapM, 1'b0);
    checkWord("csrReadValW", csrReadValW, lastRead);
    nextEdge();
    clearInputs();
    checkWord("csrReadValW", csrReadValW, exp);
    lastRead = exp;
  endtask

  // one memory-stage instruction with combinational outputs checked mid cycle
  task automatic execSys(input sysInstr_t instr, input logic [xlen-1:0] pc,
                         input logic expTrap, input logic expRet, input logic expFlush,
                         input logic [xlen-1:0] expPc);
    instrM      = instr;
    pcM         = pc;
    instrValidM = 1'b1;
    @(negedge clk);
    checkBit("trapM", trapM, expTrap);
    checkBit("retM", retM, expRet);
    checkBit("tlbFlushM", tlbFlushM, expFlush);
    checkWord("privNextPcM", privNextPcM, expPc);
    nextEdge();
    clearInputs();
  endtask

  `include "privilegedTests.svh"

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h6fa0));
    checkCount = 0;
    errorCount = 0;
    cycleCount = 0;
    lastRead   = '0;
    clearInputs();
    rstN = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rstN = 1'b1;
    // reset state
    checkMode("privModeW", privModeW, modeM);
    checkWord("csrReadValW", csrReadValW, '0);
    checkBit("trapM", trapM, 1'b0);
    checkBit("retM", retM, 1'b0);
    checkBit("tlbFlushM", tlbFlushM, 1'b0);

    csrRoundTrip();
    ecallInM();
    returnAndDelegate();
    faultPipeline();
    illegalOps();
    trapPriority();

    $display("summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: src/privileged.sv
/* privileged unit top level joining fault pipe, decode, trap unit and CSRs */
module privileged (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     stallD,
  input  logic                     stallE,
  input  logic                     stallM,
  input  logic                     stallW,
  input  logic                     flushD,
  input  logic                     flushE,
  input  logic                     flushM,
  input  logic                     instrAccessFaultF,
  input  logic                     instrPageFaultF,
  input  logic                     illegalInstrD,
  input  privPkg::sysInstr_t       instrM,
  input  logic                     instrValidM,
  input  logic [privPkg::xlen-1:0] pcM,
  input  logic [privPkg::xlen-1:0] srcAM,
  input  logic                     csrReadM,
  input  logic                     csrWriteM,
  input  logic                     loadAccessFaultM,
  input  logic                     storeAccessFaultM,
  output logic                     trapM,
  output logic                     retM,
  output logic [privPkg::xlen-1:0] privNextPcM,
  output logic                     tlbFlushM,
  output logic [1:0]               privModeW,
  output logic [privPkg::xlen-1:0] csrReadValW
);
  import privPkg::*;

  // faults arriving from the front of the pipe
  logic instrAccessFaultM, instrPageFaultM, illegalInstrM;
  // memory-stage decode
  logic mretM, sretM, ecallM, ebreakM, illegalPrivM, illegalCsrM;
  // trap and return controls into the CSRs
  logic trapToM, trapToS, retToM, retToS;
  logic [xlen-1:0] causeM;
  // live CSR state back to the trap unit
  logic [xlen-1:0] medelegM, mtvecM, stvecM, mepcM, sepcM;
  logic [1:0]      mppM;
  logic            sppM;

  faultPipe faultPipe_i (.*);

  privDecode privDecode_i (.*);

  trapUnit trapUnit_i (.*);

  csrFile csrFile_i (.*);

endmodule

// File: src/csrFile.sv
/* reduced M and S mode CSR set with trap and return updates,
   address legality and the registered read port */
module csrFile (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     stallW,
  input  privPkg::sysInstr_t       instrM,
  input  logic                     instrValidM,
  input  logic                     csrReadM,
  input  logic                     csrWriteM,
  input  logic [privPkg::xlen-1:0] srcAM,
  input  logic [privPkg::xlen-1:0] pcM,
  input  logic [1:0]               privModeW,
  input  logic                     trapToM,
  input  logic                     trapToS,
  input  logic                     retToM,
  input  logic                     retToS,
  input  logic [privPkg::xlen-1:0] causeM,
  output logic                     illegalCsrM,
  output logic [privPkg::xlen-1:0] medelegM,
  output logic [1:0]               mppM,
  output logic                     sppM,
  output logic [privPkg::xlen-1:0] mtvecM,
  output logic [privPkg::xlen-1:0] stvecM,
  output logic [privPkg::xlen-1:0] mepcM,
  output logic [privPkg::xlen-1:0] sepcM,
  output logic [privPkg::xlen-1:0] csrReadValW
);
  import privPkg::*;

  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mcause;
  logic [xlen-1:0] scause;
  logic [xlen-1:0] mstatusWr;
  logic [xlen-1:0] readValM;
  logic [11:0]     csrAddr;
  logic            knownM;
  logic            writeEnM;
  logic            readEnM;

  assign csrAddr = instrM.csrView.csrAddr;

  ////////////////////////////////////////////////////////////
  // address decode and legality
  ////////////////////////////////////////////////////////////

  always_comb begin
    knownM   = 1'b1;
    readValM = '0;
    case (csrAddr)
      csrMstatus: readValM = mstatus;
      // sstatus exposes only SIE, SPIE and SPP
      csrSstatus: readValM = mstatus & sstatusMask;
      csrMedeleg: readValM = medelegM;
      csrMtvec:   readValM = mtvecM;
      csrMepc:    readValM = mepcM;
      csrMcause:  readValM = mcause;
      csrStvec:   readValM = stvecM;
      csrSepc:    readValM = sepcM;
      csrScause:  readValM = scause;
      default:    knownM = 1'b0;
    endcase
  end

  // bits 9:8 give the lowest mode allowed to touch the CSR
  assign illegalCsrM = instrValidM && (csrReadM || csrWriteM)
                       && (!knownM || csrAddr[9:8] > privModeW);

  // illegal accesses trap and are blocked with the trap
  assign writeEnM = instrValidM && csrWriteM && !trapToM && !trapToS;
  assign readEnM  = instrValidM && csrReadM && !illegalCsrM;

  ////////////////////////////////////////////////////////////
  // mstatus
  ////////////////////////////////////////////////////////////

  // reserved MPP encoding 10 falls back to U
  always_comb begin
    mstatusWr = srcAM & mstatusMask;
    if (srcAM[mstatusMpp +: 2] == 2'b10) begin
      mstatusWr[mstatusMpp +: 2] = modeU;
    end
  end

  // trap and return updates win over software writes
  always_ff @(posedge clk) begin
    if (!rstN) begin
      mstatus <= '0;
    end else if (!stallW) begin
      if (trapToM) begin
        mstatus[mstatusMpie]     <= mstatus[mstatusMie];
        mstatus[mstatusMie]      <= 1'b0;
        mstatus[mstatusMpp +: 2] <= privModeW;
      end else if (trapToS) begin
        mstatus[mstatusSpie] <= mstatus[mstatusSie];
        mstatus[mstatusSie]  <= 1'b0;
        mstatus[mstatusSpp]  <= privModeW[0];
      end else if (retToM) begin
        mstatus[mstatusMie]      <= mstatus[mstatusMpie];
        mstatus[mstatusMpie]     <= 1'b1;
        mstatus[mstatusMpp +: 2] <= modeU;
      end else if (retToS) begin
        mstatus[mstatusSie]  <= mstatus[mstatusSpie];
        mstatus[mstatusSpie] <= 1'b1;
        mstatus[mstatusSpp]  <= 1'b0;
      end else if (writeEnM && csrAddr == csrMstatus) begin
        mstatus <= mstatusWr;
      end else if (writeEnM && csrAddr == csrSstatus) begin
        mstatus <= (mstatus & ~sstatusMask) | (srcAM & sstatusMask);
      end
    end
  end

  assign mppM = mstatus[mstatusMpp +: 2];
  assign sppM = mstatus[mstatusSpp];

  ////////////////////////////////////////////////////////////
  // delegation, vectors, epc and cause
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      medelegM <= '0;
      mtvecM   <= '0;
      mepcM    <= '0;
      mcause   <= '0;
      stvecM   <= '0;
      sepcM    <= '0;
      scause   <= '0;
    end else if (!stallW) begin
      if (trapToM) begin
        mepcM  <= pcM;
        mcause <= causeM;
      end else if (trapToS) begin
        sepcM  <= pcM;
        scause <= causeM;
      end else if (writeEnM) begin
        case (csrAddr)
          csrMedeleg: medelegM <= srcAM;
          // direct mode only
          csrMtvec:   mtvecM <= {srcAM[xlen-1:2], 2'b00};
          csrMepc:    mepcM <= srcAM;
          csrMcause:  mcause <= srcAM;
          csrStvec:   stvecM <= {srcAM[xlen-1:2], 2'b00};
          csrSepc:    sepcM <= srcAM;
          csrScause:  scause <= srcAM;
          default:    ;
        endcase
      end
    end
  end

  // read data lands in W and holds until the next read
  always_ff @(posedge clk) begin
    if (!rstN) begin
      csrReadValW <= '0;
    end else if (!stallW && readEnM) begin
      csrReadValW <= readValM;
    end
  end

  // write blocking depends on every illegal access being taken as a trap
  illegalCsrTraps: assert property (@(posedge clk) disable iff (!rstN)
    illegalCsrM |-> trapToM || trapToS);

endmodule

// File: src/trapUnit.sv
/* exception priority, delegation to S or M, privilege mode register
   and trap or return target PC */
module trapUnit (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     stallW,
  input  logic                     instrValidM,
  input  logic                     instrAccessFaultM,
  input  logic                     instrPageFaultM,
  input  logic                     illegalInstrM,
  input  logic                     illegalPrivM,
  input  logic                     illegalCsrM,
  input  logic                     mretM,
  input  logic                     sretM,
  input  logic                     ecallM,
  input  logic                     ebreakM,
  input  logic                     loadAccessFaultM,
  input  logic                     storeAccessFaultM,
  input  logic [privPkg::xlen-1:0] medelegM,
  input  logic [1:0]               mppM,
  input  logic                     sppM,
  input  logic [privPkg::xlen-1:0] mtvecM,
  input  logic [privPkg::xlen-1:0] stvecM,
  input  logic [privPkg::xlen-1:0] mepcM,
  input  logic [privPkg::xlen-1:0] sepcM,
  output logic                     trapM,
  output logic                     retM,
  output logic                     trapToM,
  output logic                     trapToS,
  output logic                     retToM,
  output logic                     retToS,
  output logic [privPkg::xlen-1:0] causeM,
  output logic [privPkg::xlen-1:0] privNextPcM,
  output logic [1:0]               privModeW
);
  import privPkg::*;

  logic       excM;
  logic       delegS;
  logic [1:0] nextModeM;

  ////////////////////////////////////////////////////////////
  // exception priority
  ////////////////////////////////////////////////////////////

  // first match wins
  always_comb begin
    excM   = 1'b1;
    causeM = '0;
    if (instrPageFaultM) begin
      causeM = causeInstrPage;
    end else if (instrAccessFaultM) begin
      causeM = causeInstrAccess;
    end else if (illegalInstrM || illegalPrivM || illegalCsrM) begin
      causeM = causeIllegal;
    end else if (ebreakM) begin
      causeM = causeBreakpoint;
    end else if (ecallM) begin
      causeM = causeEcallU + xlen'(privModeW);
    end else if (loadAccessFaultM) begin
      causeM = causeLoadAccess;
    end else if (storeAccessFaultM) begin
      causeM = causeStoreAccess;
    end else begin
      excM = 1'b0;
    end
  end

  assign trapM = instrValidM && excM;
  // a trap on the same instruction cancels the return
  assign retM  = instrValidM && (mretM || sretM) && !trapM;

  // M mode traps never go down to S
  assign delegS  = privModeW != modeM && medelegM[causeM[$clog2(xlen)-1:0]];
  assign trapToS = trapM && delegS;
  assign trapToM = trapM && !delegS;
  assign retToM  = retM && mretM;
  assign retToS  = retM && sretM;

  // redirect target
  always_comb begin
    if (trapToM) privNextPcM = mtvecM;
    else if (trapToS) privNextPcM = stvecM;
    else if (retToM) privNextPcM = mepcM;
    else if (retToS) privNextPcM = sepcM;
    else privNextPcM = '0;
  end

  ////////////////////////////////////////////////////////////
  // privilege mode register
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (trapToM) nextModeM = modeM;
    else if (trapToS) nextModeM = modeS;
    else if (retToM) nextModeM = mppM;
    else if (retToS) nextModeM = {1'b0, sppM};
    else nextModeM = privModeW;
  end

  // core starts in M mode
  always_ff @(posedge clk) begin
    if (!rstN) begin
      privModeW <= modeM;
    end else if (!stallW) begin
      privModeW <= nextModeM;
    end
  end

  trapOneTarget: assert property (@(posedge clk) disable iff (!rstN)
    !(trapToM && trapToS));

endmodule

// File: src/privDecode.sv
/* memory-stage decode of mret, sret, ecall, ebreak and sfence.vma */
module privDecode (
  input  privPkg::sysInstr_t instrM,
  input  logic               instrValidM,
  input  logic [1:0]         privModeW,
  output logic               mretM,
  output logic               sretM,
  output logic               ecallM,
  output logic               ebreakM,
  output logic               tlbFlushM,
  output logic               illegalPrivM
);
  import privPkg::*;

  logic isPriv;
  logic noRs1;
  logic isMret;
  logic isSret;
  logic isSfence;

  // valid SYSTEM word with funct3 zero and no destination
  assign isPriv = instrValidM && instrM.csrView.opcode == opSystem
                  && instrM.csrView.funct3 == f3Priv && instrM.csrView.rd == '0;
  assign noRs1  = instrM.csrView.rs1 == '0;

  // return, ecall and ebreak forms use the full funct12 field
  assign isMret  = isPriv && noRs1 && instrM.csrView.csrAddr == funct12Mret;
  assign isSret  = isPriv && noRs1 && instrM.csrView.csrAddr == funct12Sret;
  assign ecallM  = isPriv && noRs1 && instrM.csrView.csrAddr == funct12Ecall;
  assign ebreakM = isPriv && noRs1 && instrM.csrView.csrAddr == funct12Ebreak;

  // sfence.vma matches on funct7 alone
  // rs1 and rs2 select address and ASID and are ignored here
  assign isSfence = isPriv && instrM.fenceView.funct7 == funct7SfenceVma;

  ////////////////////////////////////////////////////////////
  // privilege checks
  ////////////////////////////////////////////////////////////

  // mret needs M, sret and sfence.vma need at least S
  assign illegalPrivM = (isMret && privModeW != modeM)
                        || (isSret && privModeW == modeU)
                        || (isSfence && privModeW == modeU);

  // a disallowed form only shows up as illegalPrivM
  assign mretM     = isMret && privModeW == modeM;
  assign sretM     = isSret && privModeW != modeU;
  assign tlbFlushM = isSfence && privModeW != modeU;

  // decode outputs never overlap
  decodeOneHot: assert final
    ($onehot0({mretM, sretM, ecallM, ebreakM, tlbFlushM, illegalPrivM}));

endmodule

// File: src/faultPipe.sv
/* fetch and decode fault flags carried down to the memory stage */
module faultPipe (
  input  logic clk,
  input  logic rstN,
  input  logic stallD,
  input  logic stallE,
  input  logic stallM,
  input  logic flushD,
  input  logic flushE,
  input  logic flushM,
  input  logic instrAccessFaultF,
  input  logic instrPageFaultF,
  input  logic illegalInstrD,
  output logic instrAccessFaultM,
  output logic instrPageFaultM,
  output logic illegalInstrM
);

  // D bank holds {page, access}
  logic [1:0] faultD;
  // E and M banks hold {illegal, page, access}
  logic [2:0] faultE;
  logic [2:0] faultM;

  ////////////////////////////////////////////////////////////
  // fault register banks
  ////////////////////////////////////////////////////////////

  // fetch faults enter at decode
  always_ff @(posedge clk) begin
    if (!rstN || flushD) begin
      faultD <= '0;
    end else if (!stallD) begin
      faultD <= {instrPageFaultF, instrAccessFaultF};
    end
  end

  // illegal instruction joins at execute
  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin
      faultE <= '0;
    end else if (!stallE) begin
      faultE <= {illegalInstrD, faultD};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN || flushM) begin
      faultM <= '0;
    end else if (!stallM) begin
      faultM <= faultE;
    end
  end

  assign illegalInstrM     = faultM[2];
  assign instrPageFaultM   = faultM[1];
  assign instrAccessFaultM = faultM[0];

  // a flushed bank is empty on the next cycle even under stall
  flushClears: assert property (@(posedge clk) disable iff (!rstN)
    (flushD |=> faultD == '0) and (flushE |=> faultE == '0)
    and (flushM |=> faultM == '0));

endmodule

// File: src/privPkg.sv
/* shared privilege unit definitions: word width, mode and cause codes,
   CSR addresses, mstatus field positions and the system instruction union */
package privPkg;

  // data and address width
  localparam int xlen = 32;

  // privilege mode encodings
  localparam logic [1:0] modeU = 2'b00;
  localparam logic [1:0] modeS = 2'b01;
  localparam logic [1:0] modeM = 2'b11;

  // exception cause codes
  localparam logic [xlen-1:0] causeInstrAccess = 1;
  localparam logic [xlen-1:0] causeIllegal     = 2;
  localparam logic [xlen-1:0] causeBreakpoint  = 3;
  localparam logic [xlen-1:0] causeLoadAccess  = 5;
  localparam logic [xlen-1:0] causeStoreAccess = 7;
  // ecall cause is this base plus the mode code
  localparam logic [xlen-1:0] causeEcallU      = 8;
  localparam logic [xlen-1:0] causeInstrPage   = 12;

  // machine CSR addresses
  localparam logic [11:0] csrMstatus = 12'h300;
  localparam logic [11:0] csrMedeleg = 12'h302;
  localparam logic [11:0] csrMtvec   = 12'h305;
  localparam logic [11:0] csrMepc    = 12'h341;
  localparam logic [11:0] csrMcause  = 12'h342;
  // supervisor CSR addresses
  localparam logic [11:0] csrSstatus = 12'h100;
  localparam logic [11:0] csrStvec   = 12'h105;
  localparam logic [11:0] csrSepc    = 12'h141;
  localparam logic [11:0] csrScause  = 12'h142;

  // mstatus bit positions
  localparam int mstatusSie  = 1;
  localparam int mstatusMie  = 3;
  localparam int mstatusSpie = 5;
  localparam int mstatusMpie = 7;
  localparam int mstatusSpp  = 8;
  // low bit of the two-bit MPP field
  localparam int mstatusMpp  = 11;

  // implemented mstatus bits and the subset seen through sstatus
  localparam logic [xlen-1:0] mstatusMask = 32'h0000_19aa;
  localparam logic [xlen-1:0] sstatusMask = 32'h0000_0122;

  // opcode and function fields of the SYSTEM instructions
  localparam logic [6:0]  opSystem        = 7'b1110011;
  localparam logic [2:0]  f3Priv          = 3'b000;
  localparam logic [11:0] funct12Ecall    = 12'h000;
  localparam logic [11:0] funct12Ebreak   = 12'h001;
  localparam logic [11:0] funct12Sret     = 12'h102;
  localparam logic [11:0] funct12Mret     = 12'h302;
  localparam logic [6:0]  funct7SfenceVma = 7'b0001001;

  // one SYSTEM word read either as a CSR form or as a fence form
  typedef union packed {
    struct packed {
      logic [11:0] csrAddr;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } csrView;
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } fenceView;
  } sysInstr_t;

endpackage
